//--- imuldiv.f
logic/imuldiv_pkg.sv
logic/imuldiv_iter_counter.sv
logic/imuldiv_fsm.sv
logic/imuldiv_mul_dpath.sv
logic/imuldiv_div_dpath.sv
logic/imuldiv_sign_fix.sv
logic/imuldiv_iterative.sv
tb/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  - logic/imuldiv_pkg.sv
  - logic/imuldiv_iter_counter.sv
  - logic/imuldiv_fsm.sv
  - logic/imuldiv_mul_dpath.sv
  - logic/imuldiv_div_dpath.sv
  - logic/imuldiv_sign_fix.sv
  - logic/imuldiv_iterative.sv
  - target: test
    files:
      - tb/imuldiv_tb.sv

//--- tb/imuldiv_tb.sv
// --------------------------------------------------------------------
// imuldiv testbench
// random and corner requests, back-pressure and latency checks
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_tb;

  localparam int wait_limit = 400;

  logic        clk = 1'b0;
  logic        reset;
  logic [1:0]  req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        req_val;
  logic        req_rdy;
  logic [63:0] resp_result;
  logic        resp_val;
  logic        resp_rdy;

  // separate streams so the two drivers never race on one state
  logic [31:0] stim_lfsr = 32'hdfd3ab7f;
  logic [31:0] bp_lfsr   = 32'hdfd3ab7f;
  logic [31:0] bp_bits;

  logic [63:0] exp_q[$];
  string       name_q[$];
  string       test_name = "reset";
  int          mismatches = 0;
  int          protocol_errs = 0;
  int          timeouts = 0;
  bit          aborted = 1'b0;
  bit          bp_en = 1'b0;
  int          bp_hold = 0;
  logic [63:0] held;
  bit          held_valid = 1'b0;
  int          lat_cnt = 0;
  bit          lat_run = 1'b0;
  logic [63:0] expected;
  logic [31:0] corner[5] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;

  imuldiv_iterative dut_i (.*);

  always #2 clk = ~clk;

  // ------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------

  // galois lfsr, x^32+x^22+x^2+x+1, one step per bit taken
  function automatic void take_bits(input int n, inout logic [31:0] st,
                                    output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v  = {v[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ 32'h80200003) : (st >> 1);
    end
  endfunction

  // expected response straight from the multiply/divide rules
  function automatic logic [63:0] model_result(input logic [1:0] fn,
                                               input logic [31:0] x, input logic [31:0] y);
    logic [63:0] res;
    case (fn)
      imuldiv_pkg::fn_mul:  res = {{32{x[31]}}, x} * {{32{y[31]}}, y};
      imuldiv_pkg::fn_mulu: res = {32'b0, x} * {32'b0, y};
      imuldiv_pkg::fn_div: begin
        if (y == 0) res = {x, 32'hffffffff};
        else if (x == 32'h80000000 && y == 32'hffffffff) res = {32'h0, 32'h80000000};
        else res = {$signed(x) % $signed(y), $signed(x) / $signed(y)};
      end
      default: begin
        if (y == 0) res = {x, 32'hffffffff};
        else res = {x % y, x / y};
      end
    endcase
    return res;
  endfunction

  // waits for req_rdy at the falling edge, then offers one request
  task automatic send_request(input logic [1:0] fn, input logic [31:0] x, input logic [31:0] y);
    int waited;
    waited = 0;
    while (!aborted && !req_rdy) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) begin
        $display("timed out waiting for response (%s)", test_name);
        timeouts++;
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      req_fn  = fn;
      req_a   = x;
      req_b   = y;
      req_val = 1'b1;
      @(negedge clk);
      req_val = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!aborted && exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) begin
        $display("timed out waiting for response (%s)", test_name);
        timeouts++;
        aborted = 1'b1;
      end
    end
  endtask

  // resp_rdy low for 0 to 7 cycles between single ready cycles
  always @(negedge clk) begin
    if (bp_en && bp_hold > 0) begin
      resp_rdy = 1'b0;
      bp_hold--;
    end else begin
      resp_rdy = 1'b1;
      if (bp_en) begin
        take_bits(3, bp_lfsr, bp_bits);
        bp_hold = bp_bits;
      end
    end
  end

  // ------------------------------------------------------------------
  // compare process
  // ------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (lat_run) lat_cnt++;
      if (resp_val) begin
        assert (!req_rdy) else begin
          $display("req_rdy high while a response is pending (%s)", test_name);
          protocol_errs++;
        end
        // first valid edge after the accepting edge
        if (lat_run) begin
          lat_run = 1'b0;
          assert (lat_cnt == 33) else begin
            $display("mismatch %s latency: expected 33, actual %0d", test_name, lat_cnt);
            mismatches++;
          end
        end
        if (held_valid) begin
          assert (resp_result == held) else begin
            $display("mismatch %s hold: expected %h, actual %h", test_name, held, resp_result);
            mismatches++;
          end
        end
        held       = resp_result;
        held_valid = !resp_rdy;
        if (resp_rdy) begin
          if (exp_q.size() == 0) begin
            $display("response arrived with no request pending");
            protocol_errs++;
          end else begin
            expected = exp_q.pop_front();
            assert (resp_result == expected) else begin
              $display("mismatch %s: expected %h, actual %h", name_q[0], expected, resp_result);
              mismatches++;
            end
            void'(name_q.pop_front());
          end
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(model_result(req_fn, req_a, req_b));
        name_q.push_back(test_name);
        lat_cnt = 0;
        lat_run = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_fn   = '0;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (req_rdy && !resp_val) else begin
      $display("req_rdy low or resp_val high after reset");
      protocol_errs++;
    end

    test_name = "mul_random";
    for (int i = 0; i < 200; i++) begin
      take_bits(32, stim_lfsr, a);
      take_bits(32, stim_lfsr, b);
      take_bits(1, stim_lfsr, r);
      send_request(r[0] ? imuldiv_pkg::fn_mul : imuldiv_pkg::fn_mulu, a, b);
    end

    // divisor shrunk by a random arithmetic shift, sign kept
    test_name = "div_random";
    for (int i = 0; i < 200; i++) begin
      take_bits(32, stim_lfsr, a);
      take_bits(32, stim_lfsr, b);
      take_bits(5, stim_lfsr, r);
      b = $signed(b) >>> r;
      take_bits(1, stim_lfsr, r);
      send_request(r[0] ? imuldiv_pkg::fn_div : imuldiv_pkg::fn_divu, a, b);
    end

    test_name = "corner";
    for (int f = 0; f < 4; f++)
      for (int i = 0; i < 5; i++)
        for (int j = 0; j < 5; j++)
          send_request(f[1:0], corner[i], corner[j]);

    test_name = "div_zero";
    for (int i = 0; i < 20; i++) begin
      take_bits(32, stim_lfsr, a);
      send_request(i[0] ? imuldiv_pkg::fn_div : imuldiv_pkg::fn_divu, a, 32'h0);
    end

    test_name = "backpressure";
    bp_en     = 1'b1;
    for (int i = 0; i < 60; i++) begin
      take_bits(32, stim_lfsr, a);
      take_bits(32, stim_lfsr, b);
      take_bits(2, stim_lfsr, r);
      send_request(r[1:0], a, b);
    end
    wait_drain();
    bp_en = 1'b0;

    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatches, protocol_errs, timeouts);
    if (mismatches == 0 && protocol_errs == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- logic/imuldiv_iterative.sv
// --------------------------------------------------------------------
// imuldiv iterative unit
// 32-cycle multiply/divide with val/rdy request and response ports
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_iterative (
  input  logic                           clk,
  input  logic                           reset,

  // request
  input  logic [1:0]                     req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]   req_a,
  input  logic [imuldiv_pkg::xlen-1:0]   req_b,
  input  logic                           req_val,
  output logic                           req_rdy,

  // response
  output logic [2*imuldiv_pkg::xlen-1:0] resp_result,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  logic                       load;
  logic                       step;
  logic                       last;
  imuldiv_pkg::imuldiv_resp_u mul_result;
  imuldiv_pkg::imuldiv_resp_u div_result;

  // ------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------

  imuldiv_fsm fsm_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .last     (last),
    .load     (load),
    .step     (step)
  );

  imuldiv_iter_counter counter_i (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .last  (last)
  );

  // ------------------------------------------------------------------
  // datapaths
  // ------------------------------------------------------------------

  // both run every operation, the result stage picks one
  imuldiv_mul_dpath mul_i (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .req_fn (req_fn),
    .req_a  (req_a),
    .req_b  (req_b),
    .result (mul_result)
  );

  imuldiv_div_dpath div_i (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .req_fn (req_fn),
    .req_a  (req_a),
    .req_b  (req_b),
    .result (div_result)
  );

  imuldiv_sign_fix sign_fix_i (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .mul_result  (mul_result),
    .div_result  (div_result),
    .resp_result (resp_result)
  );

endmodule

//--- logic/imuldiv_sign_fix.sv
// --------------------------------------------------------------------
// imuldiv result stage
// selects the finished datapath result and restores operand signs
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_sign_fix (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              load,
  input  logic [1:0]                        req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]      req_a,
  input  logic [imuldiv_pkg::xlen-1:0]      req_b,
  input  imuldiv_pkg::imuldiv_resp_u        mul_result,
  input  imuldiv_pkg::imuldiv_resp_u        div_result,
  output logic [2*imuldiv_pkg::xlen-1:0]    resp_result
);

  logic                         signed_fn;
  logic [1:0]                   fn_q;
  // result negative, only ever set for signed functions
  logic                         neg_q;
  // dividend negative, decides the remainder sign
  logic                         a_neg_q;
  logic                         b_zero_q;
  // raw dividend for the divide-by-zero remainder
  logic [imuldiv_pkg::xlen-1:0] a_q;

  assign signed_fn = (req_fn == imuldiv_pkg::fn_mul) || (req_fn == imuldiv_pkg::fn_div);

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q     <= imuldiv_pkg::fn_mul;
      neg_q    <= 1'b0;
      a_neg_q  <= 1'b0;
      b_zero_q <= 1'b0;
    end else if (load) begin
      fn_q     <= req_fn;
      neg_q    <= signed_fn && (req_a[imuldiv_pkg::xlen-1] ^ req_b[imuldiv_pkg::xlen-1]);
      a_neg_q  <= signed_fn && req_a[imuldiv_pkg::xlen-1];
      b_zero_q <= (req_b == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      a_q <= req_a;
    end
  end

  // ------------------------------------------------------------------
  // result select and sign correction
  // ------------------------------------------------------------------

  always_comb begin
    if (fn_q == imuldiv_pkg::fn_mul || fn_q == imuldiv_pkg::fn_mulu) begin
      resp_result = neg_q ? (~mul_result.product + 1'b1) : mul_result.product;
    end else if (b_zero_q) begin
      // quotient already all ones, remainder is the untouched dividend
      resp_result = {a_q, div_result.div.quo};
    end else begin
      resp_result[imuldiv_pkg::xlen-1:0] =
        neg_q ? (~div_result.div.quo + 1'b1) : div_result.div.quo;
      resp_result[2*imuldiv_pkg::xlen-1:imuldiv_pkg::xlen] =
        a_neg_q ? (~div_result.div.rem + 1'b1) : div_result.div.rem;
    end
  end

endmodule

//--- logic/imuldiv_div_dpath.sv
// --------------------------------------------------------------------
// imuldiv divider datapath
// restoring division of operand magnitudes, one quotient bit per step
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_div_dpath (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              load,
  input  logic                              step,
  input  logic [1:0]                        req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]      req_a,
  input  logic [imuldiv_pkg::xlen-1:0]      req_b,
  output imuldiv_pkg::imuldiv_resp_u        result
);

  logic                           signed_op;
  logic [imuldiv_pkg::xlen-1:0]   mag_a;
  logic [imuldiv_pkg::xlen-1:0]   mag_b;

  logic [imuldiv_pkg::xlen-1:0]   divisor_q;
  // upper half is the partial remainder, lower half holds the
  // remaining dividend bits and collects quotient bits from the right
  logic [2*imuldiv_pkg::xlen-1:0] sr_q;

  // shifted partial remainder, one bit wider to keep its msb
  logic [imuldiv_pkg::xlen:0]     partial;
  logic [imuldiv_pkg::xlen:0]     diff;
  logic                           underflow;

  // ------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------

  assign signed_op = (req_fn == imuldiv_pkg::fn_div);

  assign mag_a = (signed_op && req_a[imuldiv_pkg::xlen-1]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (signed_op && req_b[imuldiv_pkg::xlen-1]) ? (~req_b + 1'b1) : req_b;

  // ------------------------------------------------------------------
  // trial subtraction
  // ------------------------------------------------------------------

  // upper word after a left shift by one
  assign partial   = sr_q[2*imuldiv_pkg::xlen-1:imuldiv_pkg::xlen-1];
  assign diff      = partial - {1'b0, divisor_q};
  // borrow out means the divisor does not fit
  // a zero divisor never borrows, giving all-ones quotient
  assign underflow = diff[imuldiv_pkg::xlen];

  always_ff @(posedge clk) begin
    if (load) begin
      divisor_q <= mag_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sr_q <= '0;
    end else if (load) begin
      sr_q <= {{imuldiv_pkg::xlen{1'b0}}, mag_a};
    end else if (step) begin
      if (underflow) begin
        // restore, quotient bit 0
        sr_q <= {sr_q[2*imuldiv_pkg::xlen-2:0], 1'b0};
      end else begin
        // keep the difference, quotient bit 1
        sr_q <= {diff[imuldiv_pkg::xlen-1:0], sr_q[imuldiv_pkg::xlen-2:0], 1'b1};
      end
    end
  end

  // remainder upper, quotient lower, both magnitudes
  assign result.div.rem = sr_q[2*imuldiv_pkg::xlen-1:imuldiv_pkg::xlen];
  assign result.div.quo = sr_q[imuldiv_pkg::xlen-1:0];

endmodule

//--- logic/imuldiv_mul_dpath.sv
// --------------------------------------------------------------------
// imuldiv multiplier datapath
// shift-and-add multiply of operand magnitudes over 32 steps
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_mul_dpath (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              load,
  input  logic                              step,
  input  logic [1:0]                        req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]      req_a,
  input  logic [imuldiv_pkg::xlen-1:0]      req_b,
  output imuldiv_pkg::imuldiv_resp_u        result
);

  logic                           signed_op;
  logic [imuldiv_pkg::xlen-1:0]   mag_a;
  logic [imuldiv_pkg::xlen-1:0]   mag_b;

  // multiplicand widens as it shifts left, multiplier shrinks right
  logic [2*imuldiv_pkg::xlen-1:0] mcand_q;
  logic [imuldiv_pkg::xlen-1:0]   mplier_q;
  logic [2*imuldiv_pkg::xlen-1:0] acc_q;

  // ------------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------------

  // only signed multiply works on absolute values
  assign signed_op = (req_fn == imuldiv_pkg::fn_mul);

  assign mag_a = (signed_op && req_a[imuldiv_pkg::xlen-1]) ? (~req_a + 1'b1) : req_a;
  assign mag_b = (signed_op && req_b[imuldiv_pkg::xlen-1]) ? (~req_b + 1'b1) : req_b;

  // ------------------------------------------------------------------
  // operand shift registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{imuldiv_pkg::xlen{1'b0}}, mag_a};
      mplier_q <= mag_b;
    end else if (step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // ------------------------------------------------------------------
  // accumulator
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else if (load) begin
      acc_q <= '0;
    end else if (step && mplier_q[0]) begin
      // partial product for the current multiplier bit
      acc_q <= acc_q + mcand_q;
    end
  end

  // unsigned 64-bit magnitude, sign handled in the result stage
  assign result.product = acc_q;

endmodule

//--- logic/imuldiv_fsm.sv
// --------------------------------------------------------------------
// imuldiv controller
// idle/calc/done FSM for the val/rdy handshakes and datapath strobes
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_fsm (
  input  logic clk,
  input  logic reset,

  // request side
  input  logic req_val,
  output logic req_rdy,

  // response side
  output logic resp_val,
  input  logic resp_rdy,

  // from the iteration counter
  input  logic last,

  // datapath strobes
  output logic load,
  output logic step
);

  logic [1:0] state_q;
  logic [1:0] state_d;

  // ------------------------------------------------------------------
  // state register
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= imuldiv_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      imuldiv_pkg::st_idle: begin
        // request accepted, start iterating next cycle
        if (req_val) begin
          state_d = imuldiv_pkg::st_calc;
        end
      end
      imuldiv_pkg::st_calc: begin
        // 32nd step happens on this edge
        if (last) begin
          state_d = imuldiv_pkg::st_done;
        end
      end
      imuldiv_pkg::st_done: begin
        // hold the result until the consumer takes it
        if (resp_rdy) begin
          state_d = imuldiv_pkg::st_idle;
        end
      end
      default: begin
        state_d = imuldiv_pkg::st_idle;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------

  // only one operation in flight, so ready only while idle
  assign req_rdy  = (state_q == imuldiv_pkg::st_idle);
  assign resp_val = (state_q == imuldiv_pkg::st_done);

  // load marks the accepting cycle
  assign load = req_rdy && req_val;
  // one datapath iteration per calc cycle
  assign step = (state_q == imuldiv_pkg::st_calc);

  // a pending response stays offered and no new request is taken meanwhile
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && !req_rdy);

  // iterations only follow an accepted request or another iteration
  step_seq_a: assert property (@(posedge clk) disable iff (reset)
    step |-> $past(load) || $past(step));

endmodule

//--- logic/imuldiv_iter_counter.sv
// --------------------------------------------------------------------
// imuldiv iteration counter
// counts step cycles and flags the last of 32 iterations
// --------------------------------------------------------------------

`timescale 1ns/10ps

module imuldiv_iter_counter (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last
);

  logic [imuldiv_pkg::iter_bits-1:0] count_q;
  // set once the counter rolled over at the end of an operation
  logic                              wrapped_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q   <= '0;
      wrapped_q <= 1'b0;
    end else if (load) begin
      // new operation starts from iteration 0
      count_q   <= '0;
      wrapped_q <= 1'b0;
    end else if (step) begin
      count_q <= count_q + 1'b1;
      if (last) begin
        wrapped_q <= 1'b1;
      end
    end
  end

  // 32nd step cycle, count sits at 31
  assign last = (count_q == {imuldiv_pkg::iter_bits{1'b1}});

  // the fsm must stop stepping once all 32 iterations are done
  step_after_wrap_a: assert property (@(posedge clk) disable iff (reset)
    step |-> !wrapped_q);

endmodule

//--- logic/imuldiv_pkg.sv
// --------------------------------------------------------------------
// imuldiv shared definitions
// operand widths, function codes, fsm states and the result word
// --------------------------------------------------------------------

package imuldiv_pkg;

  // operand width and iteration counter width
  localparam int xlen      = 32;
  localparam int iter_bits = 5;

  // function codes carried on req_fn
  localparam logic [1:0] fn_mul  = 2'd0;
  localparam logic [1:0] fn_mulu = 2'd1;
  localparam logic [1:0] fn_div  = 2'd2;
  localparam logic [1:0] fn_divu = 2'd3;

  // controller states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  // ------------------------------------------------------------------
  // datapath result word
  // ------------------------------------------------------------------

  // one 64-bit word, read as a full product after a multiply or as
  // remainder/quotient after a divide
  typedef union packed {
    logic [2*xlen-1:0] product;
    struct packed {
      // upper word
      logic [xlen-1:0] rem;
      // lower word
      logic [xlen-1:0] quo;
    } div;
  } imuldiv_resp_u;

endpackage
